// ==== src/soc_mem_pkg.sv ====
package soc_mem_pkg;

   // bus geometry
   localparam int DATA_W      = 32;
   localparam int SRAM_ADDR_W = 12;              // byte address, 1024 words
   localparam int WORD_ADDR_W = SRAM_ADDR_W - 2;
   localparam int STRB_W      = DATA_W / 8;

   // words written by the boot loader before fetches are served
   localparam int BOOT_WORDS = 16;

   typedef logic [DATA_W-1:0]      data_t;
   typedef logic [SRAM_ADDR_W-1:0] byte_addr_t;
   typedef logic [WORD_ADDR_W-1:0] word_addr_t;
   typedef logic [STRB_W-1:0]      strb_t;
   typedef logic [1:0]             mem_size_t;

   // access sizes, same coding as the low funct3 bits
   localparam mem_size_t SIZE_B = 2'd0;
   localparam mem_size_t SIZE_H = 2'd1;
   localparam mem_size_t SIZE_W = 2'd2;

   typedef enum logic {
      BOOT_FILL,
      BOOT_DONE
   } boot_state_t;

endpackage

// ==== src/boot_loader.sv ====
module boot_loader import soc_mem_pkg::*; (
   input  logic       clk_i,
   input  logic       rst_n_i,

   // serial boot stream
   input  logic       boot_valid_i,
   input  logic [7:0] boot_byte_i,

   // word writes towards the instruction port
   output logic       bw_valid_o,
   output word_addr_t bw_addr_o,
   output data_t      bw_wdata_o,
   output logic       boot_done_o
);

   boot_state_t state;
   logic [1:0]  byte_cnt;    // bytes held for the current word
   word_addr_t  word_cnt;    // next word address
   logic [23:0] shreg;
   data_t       next_word;
   logic        take;
   logic        word_full;
   logic        last_word;

   assign take      = boot_valid_i && (state == BOOT_FILL);
   assign word_full = take && (byte_cnt == 2'd3);
   assign last_word = (word_cnt == word_addr_t'(BOOT_WORDS - 1));

   // newest byte enters at the top, so the first one ends up in bits 7:0
   assign next_word = {boot_byte_i, shreg};

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state       <= BOOT_FILL;
         byte_cnt    <= '0;
         word_cnt    <= '0;
         bw_valid_o  <= 1'b0;
         boot_done_o <= 1'b0;
      end else begin
         bw_valid_o <= word_full;     // one cycle write strobe
         // trails the state by a cycle so the last write still owns port A
         boot_done_o <= (state == BOOT_DONE);
         if (take) begin
            byte_cnt <= byte_cnt + 2'd1;
         end
         if (word_full) begin
            word_cnt <= word_cnt + word_addr_t'(1);
            if (last_word) begin
               state <= BOOT_DONE;    // later bytes are ignored
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (take) begin
         shreg <= next_word[DATA_W-1:8];
      end
      if (word_full) begin
         bw_wdata_o <= next_word;
         bw_addr_o  <= word_cnt;
      end
   end

endmodule

// ==== src/store_align.sv ====
module store_align import soc_mem_pkg::*; (
   input  logic       clk_i,
   input  logic       rst_n_i,

   // byte addressed request from the core
   input  logic       d_valid_i,
   input  logic       d_we_i,
   input  byte_addr_t d_addr_i,
   input  mem_size_t  d_size_i,
   input  logic       d_unsigned_i,
   input  data_t      d_wdata_i,

   // word request to the memory
   output logic       m_valid_o,
   output word_addr_t m_addr_o,
   output strb_t      m_wstrb_o,
   output data_t      m_wdata_o,

   // attributes of the load in flight
   output logic [1:0] ld_off_o,
   output mem_size_t  ld_size_o,
   output logic       ld_unsigned_o
);

   logic [1:0] off;
   strb_t      strb;

   always_comb begin
      off       = d_addr_i[1:0];
      strb      = '1;
      m_wdata_o = d_wdata_i;
      case (d_size_i)
         SIZE_B: begin
            strb      = strb_t'(1) << off;
            m_wdata_o = {4{d_wdata_i[7:0]}};   // byte copied into every lane
         end
         SIZE_H: begin
            off[0]    = 1'b0;                  // halfword alignment
            strb      = strb_t'(3) << off;
            m_wdata_o = {2{d_wdata_i[15:0]}};
         end
         default: off = 2'b00;                // words, also the unused code
      endcase
   end

   assign m_valid_o = d_valid_i;
   assign m_addr_o  = d_addr_i[SRAM_ADDR_W-1:2];
   assign m_wstrb_o = d_we_i ? strb : '0;     // loads carry no strobes

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ld_off_o      <= 2'b00;
         ld_size_o     <= SIZE_W;
         ld_unsigned_o <= 1'b0;
      end else if (d_valid_i && !d_we_i) begin
         ld_off_o      <= off;
         ld_size_o     <= d_size_i;
         ld_unsigned_o <= d_unsigned_i;
      end
   end

endmodule

// ==== src/ram_dp_be.sv ====
module ram_dp_be import soc_mem_pkg::*; (
   input  logic       clk_i,

   // port A
   input  logic       ena_i,
   input  word_addr_t addra_i,
   input  strb_t      wea_i,
   input  data_t      da_i,
   output data_t      qa_o,

   // port B
   input  logic       enb_i,
   input  word_addr_t addrb_i,
   input  strb_t      web_i,
   input  data_t      db_i,
   output data_t      qb_o
);

   data_t mem [0:(1 << WORD_ADDR_W)-1];

   // both ports read first; old word is returned on a write
   always_ff @(posedge clk_i) begin
      if (ena_i) begin
         qa_o <= mem[addra_i];
      end
      if (enb_i) begin
         qb_o <= mem[addrb_i];
      end

      if (ena_i) begin
         for (int i = 0; i < STRB_W; i++) begin
            if (wea_i[i]) begin
               mem[addra_i][8*i +: 8] <= da_i[8*i +: 8];
            end
         end
      end
      // port B comes last so its bytes win on a shared word
      if (enb_i) begin
         for (int i = 0; i < STRB_W; i++) begin
            if (web_i[i]) begin
               mem[addrb_i][8*i +: 8] <= db_i[8*i +: 8];
            end
         end
      end
   end

endmodule

// ==== src/sram.sv ====
module sram import soc_mem_pkg::*; (
   input  logic       clk_i,
   input  logic       rst_n_i,
   input  logic       boot_done_i,

   // boot writer
   input  logic       bw_valid_i,
   input  word_addr_t bw_addr_i,
   input  data_t      bw_wdata_i,

   // instruction fetch
   input  logic       fetch_valid_i,
   input  word_addr_t fetch_addr_i,
   output data_t      fetch_rdata_o,
   output logic       fetch_rvalid_o,

   // data bus
   input  logic       d_valid_i,
   input  word_addr_t d_addr_i,
   input  strb_t      d_wstrb_i,
   input  data_t      d_wdata_i,
   output data_t      d_rdata_o,
   output logic       d_rvalid_o
);

   logic       i_en;
   word_addr_t i_addr;
   strb_t      i_wstrb;

   // boot writes own the instruction port until boot is done
   assign i_en    = boot_done_i ? fetch_valid_i : bw_valid_i;
   assign i_addr  = boot_done_i ? fetch_addr_i  : bw_addr_i;
   assign i_wstrb = boot_done_i ? '0 : {STRB_W{bw_valid_i}};

   ram_dp_be u_ram (
      .clk_i   (clk_i),
      .ena_i   (i_en),
      .addra_i (i_addr),
      .wea_i   (i_wstrb),
      .da_i    (bw_wdata_i),
      .qa_o    (fetch_rdata_o),
      .enb_i   (d_valid_i),
      .addrb_i (d_addr_i),
      .web_i   (d_wstrb_i),
      .db_i    (d_wdata_i),
      .qb_o    (d_rdata_o)
   );

   // read valid one cycle after a request with no strobes
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         fetch_rvalid_o <= 1'b0;
         d_rvalid_o     <= 1'b0;
      end else begin
         fetch_rvalid_o <= i_en && ~(|i_wstrb);
         d_rvalid_o     <= d_valid_i && ~(|d_wstrb_i);
      end
   end

endmodule

// ==== src/load_align.sv ====
module load_align import soc_mem_pkg::*; (
   input  data_t      rdata_i,     // raw word from the memory
   input  logic [1:0] off_i,
   input  mem_size_t  size_i,
   input  logic       unsigned_i,
   output data_t      rdata_o
);

   logic [15:0] shifted;
   logic        sign_b;
   logic        sign_h;

   // addressed lane moved down to bit 0
   assign shifted = 16'(rdata_i >> {off_i, 3'b000});

   assign sign_b = shifted[7]  & ~unsigned_i;
   assign sign_h = shifted[15] & ~unsigned_i;

   always_comb begin
      case (size_i)
         SIZE_B:  rdata_o = {{(DATA_W-8){sign_b}}, shifted[7:0]};
         SIZE_H:  rdata_o = {{(DATA_W-16){sign_h}}, shifted[15:0]};
         default: rdata_o = rdata_i;      // full word untouched
      endcase
   end

endmodule

// ==== src/soc_mem_top.sv ====
module soc_mem_top import soc_mem_pkg::*; (
   input  logic       clk_i,
   input  logic       rst_n_i,

   // boot stream
   input  logic       boot_valid_i,
   input  logic [7:0] boot_byte_i,
   output logic       boot_done_o,

   // instruction fetch
   input  logic       fetch_valid_i,
   input  word_addr_t fetch_addr_i,
   output data_t      fetch_rdata_o,
   output logic       fetch_rvalid_o,

   // load/store
   input  logic       d_valid_i,
   input  logic       d_we_i,
   input  byte_addr_t d_addr_i,
   input  mem_size_t  d_size_i,
   input  logic       d_unsigned_i,
   input  data_t      d_wdata_i,
   output data_t      d_rdata_o,
   output logic       d_rvalid_o
);

   // boot loader to sram
   logic       bw_valid;
   word_addr_t bw_addr;
   data_t      bw_wdata;

   // aligned data request
   logic       m_valid;
   word_addr_t m_addr;
   strb_t      m_wstrb;
   data_t      m_wdata;

   // load attributes and raw read word
   logic [1:0] ld_off;
   mem_size_t  ld_size;
   logic       ld_unsigned;
   data_t      d_raw;

   boot_loader u_boot (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .boot_valid_i (boot_valid_i),
      .boot_byte_i  (boot_byte_i),
      .bw_valid_o   (bw_valid),
      .bw_addr_o    (bw_addr),
      .bw_wdata_o   (bw_wdata),
      .boot_done_o  (boot_done_o)
   );

   store_align u_store (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .d_valid_i     (d_valid_i),
      .d_we_i        (d_we_i),
      .d_addr_i      (d_addr_i),
      .d_size_i      (d_size_i),
      .d_unsigned_i  (d_unsigned_i),
      .d_wdata_i     (d_wdata_i),
      .m_valid_o     (m_valid),
      .m_addr_o      (m_addr),
      .m_wstrb_o     (m_wstrb),
      .m_wdata_o     (m_wdata),
      .ld_off_o      (ld_off),
      .ld_size_o     (ld_size),
      .ld_unsigned_o (ld_unsigned)
   );

   sram u_sram (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .boot_done_i    (boot_done_o),   // fetches open once boot is done
      .bw_valid_i     (bw_valid),
      .bw_addr_i      (bw_addr),
      .bw_wdata_i     (bw_wdata),
      .fetch_valid_i  (fetch_valid_i),
      .fetch_addr_i   (fetch_addr_i),
      .fetch_rdata_o  (fetch_rdata_o),
      .fetch_rvalid_o (fetch_rvalid_o),
      .d_valid_i      (m_valid),
      .d_addr_i       (m_addr),
      .d_wstrb_i      (m_wstrb),
      .d_wdata_i      (m_wdata),
      .d_rdata_o      (d_raw),
      .d_rvalid_o     (d_rvalid_o)
   );

   // combinational on the registered attributes
   load_align u_load (
      .rdata_i    (d_raw),
      .off_i      (ld_off),
      .size_i     (ld_size),
      .unsigned_i (ld_unsigned),
      .rdata_o    (d_rdata_o)
   );

endmodule

// ==== bench/soc_mem_tb.sv ====
module soc_mem_tb import soc_mem_pkg::*; ();

   localparam int CLK_PERIOD   = 10;
   localparam int RESET_CYCLES = 4;
   localparam int BOOT_GAP_MAX = 3;
   localparam int REGION_LO    = BOOT_WORDS;   // data traffic stays above the boot image
   localparam int REGION_N     = 48;
   localparam int N_STORES     = 120;
   localparam int N_LOAD_WORDS = 8;
   localparam int N_MIX        = 300;
   localparam int DRAIN        = 8;
   localparam int BOOT_CYC  = 4 * BOOT_WORDS * (BOOT_GAP_MAX + 1) + 8 + BOOT_WORDS + DRAIN;
   localparam int STORE_CYC = 2 * REGION_N + N_STORES + DRAIN;
   localparam int SUB_CYC   = 2 + N_LOAD_WORDS * 16 + DRAIN;
   localparam int MIX_CYC   = N_MIX + DRAIN;
   localparam int TEST_CYC  = RESET_CYCLES + BOOT_CYC + STORE_CYC + SUB_CYC + MIX_CYC;

   logic       clk;
   logic       rst_n;
   logic       boot_valid;
   logic [7:0] boot_byte;
   logic       boot_done;
   logic       fetch_valid;
   word_addr_t fetch_addr;
   data_t      fetch_rdata;
   logic       fetch_rvalid;
   logic       d_valid;
   logic       d_we;
   byte_addr_t d_addr;
   mem_size_t  d_size;
   logic       d_unsigned;
   data_t      d_wdata;
   data_t      d_rdata;
   logic       d_rvalid;

   data_t shadow [0:(1 << WORD_ADDR_W)-1];   // expected memory contents
   data_t f_exp_q[$];
   int    f_due_q[$];
   data_t d_exp_q[$];
   int    d_due_q[$];
   int    cyc = 0;
   logic  fetch_open = 1'b0;   // fetches answered once the boot image is in

   soc_mem_top dut_i (
      .clk_i          (clk),
      .rst_n_i        (rst_n),
      .boot_valid_i   (boot_valid),
      .boot_byte_i    (boot_byte),
      .boot_done_o    (boot_done),
      .fetch_valid_i  (fetch_valid),
      .fetch_addr_i   (fetch_addr),
      .fetch_rdata_o  (fetch_rdata),
      .fetch_rvalid_o (fetch_rvalid),
      .d_valid_i      (d_valid),
      .d_we_i         (d_we),
      .d_addr_i       (d_addr),
      .d_size_i       (d_size),
      .d_unsigned_i   (d_unsigned),
      .d_wdata_i      (d_wdata),
      .d_rdata_o      (d_rdata),
      .d_rvalid_o     (d_rvalid)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      if (act !== exp) begin
         $display("[ERROR] %0t %s: expected %h, got %h", $time, name, exp, act);
         $display("*** FAILED ***");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   task automatic abort_run(input string why);
      $display("%0t %s", $time, why);
      $display("*** FAILED ***");
      $fatal(1, "run aborted");
   endtask

   // little endian lane update for a store of the given size
   function automatic data_t store_ref(input data_t old, input logic [1:0] off,
                                       input mem_size_t size, input data_t wdata);
      data_t r;
      r = old;
      if (size == SIZE_B) begin
         case (off)
            2'd0:    r[7:0]   = wdata[7:0];
            2'd1:    r[15:8]  = wdata[7:0];
            2'd2:    r[23:16] = wdata[7:0];
            default: r[31:24] = wdata[7:0];
         endcase
      end else if (size == SIZE_H) begin
         if (off[1]) begin
            r[31:16] = wdata[15:0];
         end else begin
            r[15:0] = wdata[15:0];
         end
      end else begin
         r = wdata;                     // offset bits ignored for words
      end
      return r;
   endfunction

   function automatic data_t load_ref(input data_t word, input logic [1:0] off,
                                      input mem_size_t size, input logic uns);
      logic [7:0]  b;
      logic [15:0] h;
      data_t       r;
      case (off)
         2'd0:    b = word[7:0];
         2'd1:    b = word[15:8];
         2'd2:    b = word[23:16];
         default: b = word[31:24];
      endcase
      h = off[1] ? word[31:16] : word[15:0];
      case (size)
         SIZE_B:  r = uns ? {24'd0, b} : {{24{b[7]}}, b};
         SIZE_H:  r = uns ? {16'd0, h} : {{16{h[15]}}, h};
         default: r = word;
      endcase
      return r;
   endfunction

   // called on a falling edge; the request is taken on the next rising edge
   task automatic drive_data(input logic we, input byte_addr_t addr, input mem_size_t size,
                             input logic uns, input data_t wdata);
      word_addr_t w;
      w          = addr[SRAM_ADDR_W-1:2];
      d_valid    = 1'b1;
      d_we       = we;
      d_addr     = addr;
      d_size     = size;
      d_unsigned = uns;
      d_wdata    = wdata;
      if (we) begin
         shadow[w] = store_ref(shadow[w], addr[1:0], size, wdata);
      end else begin
         d_exp_q.push_back(load_ref(shadow[w], addr[1:0], size, uns));
         d_due_q.push_back(cyc + 2);
      end
   endtask

   task automatic drive_fetch(input logic en, input word_addr_t addr);
      fetch_valid = en;
      fetch_addr  = addr;
      if (en && fetch_open) begin       // dropped while booting
         f_exp_q.push_back(shadow[addr]);
         f_due_q.push_back(cyc + 2);
      end
   endtask

   task automatic idle_inputs();
      boot_valid  = 1'b0;
      fetch_valid = 1'b0;
      d_valid     = 1'b0;
      d_we        = 1'b0;
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while ((f_exp_q.size() != 0 || d_exp_q.size() != 0) && n < DRAIN) begin
         @(negedge clk);
         n++;
      end
      if (f_exp_q.size() != 0 || d_exp_q.size() != 0) begin
         abort_run("read responses still outstanding after the drain window");
      end
   endtask

   function automatic word_addr_t region_word();
      return word_addr_t'(REGION_LO + $urandom_range(REGION_N - 1));
   endfunction

   task automatic run_boot();
      int         gap;
      int         n;
      logic [7:0] b;
      for (int i = 0; i < 4 * BOOT_WORDS; i++) begin
         gap = $urandom_range(BOOT_GAP_MAX);
         repeat (gap) begin
            @(negedge clk);
            check_value("boot_done_o", 32'd0, 32'(boot_done));
            boot_valid = 1'b0;
            drive_fetch($urandom_range(1) == 1, word_addr_t'($urandom_range(BOOT_WORDS - 1)));
         end
         @(negedge clk);
         check_value("boot_done_o", 32'd0, 32'(boot_done));
         b          = 8'($urandom);
         boot_valid = 1'b1;
         boot_byte  = b;
         shadow[word_addr_t'(i / 4)] = store_ref(shadow[word_addr_t'(i / 4)], 2'(i % 4),
                                                 SIZE_B, {24'd0, b});
         drive_fetch($urandom_range(1) == 1, word_addr_t'($urandom_range(BOOT_WORDS - 1)));
      end
      @(negedge clk);
      idle_inputs();
      n = 0;
      while (boot_done !== 1'b1 && n < 4) begin
         @(negedge clk);
         n++;
      end
      if (boot_done !== 1'b1) begin
         abort_run("boot_done_o did not rise after the full boot image");
      end
      fetch_open = 1'b1;
      // surplus bytes must not disturb anything
      for (int i = 0; i < 4; i++) begin
         @(negedge clk);
         boot_valid = 1'b1;
         boot_byte  = 8'($urandom);
      end
      for (int i = 0; i < BOOT_WORDS; i++) begin
         @(negedge clk);
         boot_valid = 1'b0;
         check_value("boot_done_o", 32'd1, 32'(boot_done));
         drive_fetch(1'b1, word_addr_t'(i));
      end
      @(negedge clk);
      idle_inputs();
      wait_drain();
   endtask

   task automatic run_store_load();
      for (int k = 0; k < REGION_N; k++) begin
         @(negedge clk);
         drive_data(1'b1, {word_addr_t'(REGION_LO + k), 2'($urandom)}, SIZE_W, 1'b0, $urandom);
      end
      for (int k = 0; k < N_STORES; k++) begin
         @(negedge clk);
         drive_data(1'b1, {region_word(), 2'($urandom)}, mem_size_t'($urandom_range(2)),
                    1'b0, $urandom);
      end
      for (int k = 0; k < REGION_N; k++) begin
         @(negedge clk);
         drive_data(1'b0, {word_addr_t'(REGION_LO + k), 2'($urandom)}, SIZE_W, 1'b0, '0);
      end
      @(negedge clk);
      idle_inputs();
      wait_drain();
   endtask

   task automatic run_subword_loads();
      @(negedge clk);
      drive_data(1'b1, {word_addr_t'(REGION_LO), 2'd0}, SIZE_W, 1'b0, 32'hf18c_7a05);
      @(negedge clk);
      drive_data(1'b1, {word_addr_t'(REGION_LO + 1), 2'd0}, SIZE_W, 1'b0, 32'h7f80_01fe);
      for (int k = 0; k < N_LOAD_WORDS; k++) begin
         for (int s = 0; s < 2; s++) begin
            for (int o = 0; o < 4; o++) begin
               for (int u = 0; u < 2; u++) begin
                  @(negedge clk);
                  drive_data(1'b0, {word_addr_t'(REGION_LO + k), 2'(o)}, mem_size_t'(s),
                             u == 1, '0);
               end
            end
         end
      end
      @(negedge clk);
      idle_inputs();
      wait_drain();
   endtask

   task automatic run_mixed();
      logic [31:0] r;
      for (int k = 0; k < N_MIX; k++) begin
         @(negedge clk);
         r = $urandom;
         drive_data(r[2], {region_word(), r[1:0]}, mem_size_t'($urandom_range(2)),
                    r[3], $urandom);
         drive_fetch(r[4] | r[5], word_addr_t'($urandom_range(BOOT_WORDS - 1)));
      end
      @(negedge clk);
      idle_inputs();
      wait_drain();
   endtask

   // responses are due exactly one cycle after the request edge
   always @(posedge clk) begin
      cyc = cyc + 1;
      if (rst_n) begin
         if (f_due_q.size() != 0 && f_due_q[0] == cyc) begin
            check_value("fetch_rvalid_o", 32'd1, 32'(fetch_rvalid));
            check_value("fetch_rdata_o", f_exp_q[0], fetch_rdata);
            void'(f_exp_q.pop_front());
            void'(f_due_q.pop_front());
         end else begin
            check_value("fetch_rvalid_o", 32'd0, 32'(fetch_rvalid));
         end
         if (d_due_q.size() != 0 && d_due_q[0] == cyc) begin
            check_value("d_rvalid_o", 32'd1, 32'(d_rvalid));
            check_value("d_rdata_o", d_exp_q[0], d_rdata);
            void'(d_exp_q.pop_front());
            void'(d_due_q.pop_front());
         end else begin
            check_value("d_rvalid_o", 32'd0, 32'(d_rvalid));
         end
      end
   end

   initial begin
      #(2 * TEST_CYC * CLK_PERIOD);
      $display("watchdog expired before the tests completed");
      $display("*** FAILED ***");
      $fatal(1, "timeout");
   end

   initial begin
      void'($urandom(32'haa4e_ced6));
      clk        = 1'b0;
      rst_n      = 1'b0;
      boot_valid = 1'b0;
      boot_byte  = 8'h00;
      fetch_valid = 1'b0;
      fetch_addr = '0;
      d_valid    = 1'b0;
      d_we       = 1'b0;
      d_addr     = '0;
      d_size     = SIZE_W;
      d_unsigned = 1'b0;
      d_wdata    = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      run_boot();
      run_store_load();
      run_subword_loads();
      run_mixed();
      $display("*** PASSED ***");
      $finish;
   end

endmodule

// ==== vlog.f ====
src/soc_mem_pkg.sv
src/boot_loader.sv
src/store_align.sv
src/ram_dp_be.sv
src/sram.sv
src/load_align.sv
src/soc_mem_top.sv
bench/soc_mem_tb.sv

// ==== Makefile ====
# Verilator flow for the on-chip memory block
VERILATOR ?= verilator
TOP       ?= soc_mem_tb
RTL_TOP   ?= soc_mem_top
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= *** PASSED ***

RTL_FILES := $(shell grep '^src/' $(FLIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_FILES)

# the run passes only if the pass message shows up in the output
sim:
	$(VERILATOR) --binary --timing --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
